// ==== common/conv_pkg.sv ====
package conv_pkg;

    // window geometry
    parameter int CH_NUM = 4;
    parameter int TAPS   = 9;

    // datapath widths
    parameter int BW_ACT   = 8;
    parameter int BW_PARAM = 4;
    // one triple of act*weight products, with a guard bit
    parameter int BW_PSUM  = BW_ACT + BW_PARAM + 1;
    // 36 products plus bias and round, wide enough for a full-scale window
    parameter int BW_ACC   = 18;

    // upper clamp of an output pixel
    parameter int ACT_MAX = 127;

    typedef logic signed [BW_ACT-1:0]   act_t;
    typedef logic signed [BW_PARAM-1:0] param_t;
    typedef logic signed [BW_PSUM-1:0]  psum_t;
    typedef logic signed [BW_ACC-1:0]   acc_t;
    typedef logic [BW_ACT-1:0]          pix_t;

    // tap 0 sits in the top nibble
    typedef param_t [0:TAPS-1] weight_row_t;

    // group 0 sits in the top row
    typedef weight_row_t [0:CH_NUM-1] weight_set_t;

    // channel 0 tap 0 sits in the top byte
    typedef act_t [0:CH_NUM-1][0:TAPS-1] window_t;

    typedef enum logic {
        CONV1 = 1'b0,
        CONV2 = 1'b1
    } layer_mode_e;

    // wishbone register map
    parameter logic [1:0] REG_WEIGHT = 2'd0;
    parameter logic [1:0] REG_BIAS   = 2'd1;
    parameter logic [1:0] REG_MODE   = 2'd2;

endpackage

// ==== weight_bank/weight_bank.sv ====
`timescale 1ns/100ps

// four-group weight shift bank, bias and layer mode
module weight_bank
    import conv_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        push_row,
    input  weight_row_t row_data,
    input  logic        load_bias,
    input  param_t      bias_data,
    input  logic        load_mode,
    input  layer_mode_e mode_data,
    output weight_set_t weights,
    output param_t      bias,
    output layer_mode_e mode
);

    weight_set_t bank_q;
    param_t      bias_q;
    layer_mode_e mode_q;

    // new rows enter at group 3, oldest leaves from group 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bank_q <= '0;
        end else if (push_row) begin
            bank_q <= {bank_q[1:CH_NUM-1], row_data};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bias_q <= '0;
        end else if (load_bias) begin
            bias_q <= bias_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mode_q <= CONV1;
        end else if (load_mode) begin
            mode_q <= mode_data;
        end
    end

    // read live by every pipeline stage
    assign weights = bank_q;
    assign bias    = bias_q;
    assign mode    = mode_q;

endmodule

// ==== mac_pipe/requant_relu.sv ====
`timescale 1ns/100ps

// bias align, round, shift back down, clamp to 0..ACT_MAX
module requant_relu
    import conv_pkg::*;
(
    input  acc_t        acc,
    input  param_t      bias,
    input  layer_mode_e mode,
    output pix_t        pix
);

    acc_t bias_al;
    acc_t round_c;
    acc_t sum;
    acc_t shifted;

    always_comb begin
        if (mode == CONV1) begin
            // conv1: bias << 7, +64, >> 7
            bias_al = acc_t'(bias) <<< 7;
            round_c = acc_t'(64);
        end else begin
            // conv2: bias << 3, +16, >> 5
            bias_al = acc_t'(bias) <<< 3;
            round_c = acc_t'(16);
        end

        sum = acc + bias_al + round_c;

        if (mode == CONV1) begin
            shifted = sum >>> 7;
        end else begin
            shifted = sum >>> 5;
        end

        // relu with upper clamp
        if (shifted < 0) begin
            pix = '0;
        end else if (shifted > ACT_MAX) begin
            pix = pix_t'(ACT_MAX);
        end else begin
            pix = pix_t'(shifted);
        end
    end

endmodule

// ==== mac_pipe/mac_pipe.sv ====
`timescale 1ns/100ps

// window -> triples -> accumulator -> pixel, never stalls
module mac_pipe
    import conv_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        win_valid,
    input  window_t     win_data,
    input  weight_set_t weights,
    input  param_t      bias,
    input  layer_mode_e mode,
    output logic        pix_valid,
    output pix_t        pix_data
);

    localparam int TRIPLES = TAPS / 3;
    localparam int DEPTH   = 4;

    // stage 1
    window_t win_q;

    // stage 2
    psum_t triple_d [CH_NUM][TRIPLES];
    psum_t triple_q [CH_NUM][TRIPLES];

    // stage 3
    acc_t acc_d;
    acc_t acc_q;

    // stage 4
    pix_t pix_d;
    pix_t pix_q;

    logic [DEPTH-1:0] vld_q;

    // channel c taps 3k..3k+2 against weight group c, same taps
    always_comb begin
        for (int c = 0; c < CH_NUM; c++) begin
            for (int k = 0; k < TRIPLES; k++) begin
                triple_d[c][k] = '0;
                for (int t = 0; t < 3; t++) begin
                    triple_d[c][k] = triple_d[c][k]
                        + psum_t'($signed(win_q[c][3*k+t]))
                        * psum_t'($signed(weights[c][3*k+t]));
                end
            end
        end
    end

    // twelve triples into one accumulator
    always_comb begin
        acc_d = '0;
        for (int c = 0; c < CH_NUM; c++) begin
            for (int k = 0; k < TRIPLES; k++) begin
                acc_d = acc_d + acc_t'(triple_q[c][k]);
            end
        end
    end

    requant_relu u_requant (
        .acc  (acc_q),
        .bias (bias),
        .mode (mode),
        .pix  (pix_d)
    );

    always_ff @(posedge clk) begin
        win_q    <= win_data;
        triple_q <= triple_d;
        acc_q    <= acc_d;
        pix_q    <= pix_d;
    end

    // valid travels one stage per cycle beside the data
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[DEPTH-2:0], win_valid};
        end
    end

    assign pix_valid = vld_q[DEPTH-1];
    assign pix_data  = pix_q;

endmodule

// ==== hdl/param_port.sv ====
`timescale 1ns/100ps

module param_port
    import conv_pkg::*;
#(
    parameter int WB_DAT_W = 36
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [1:0]          wb_adr,
    input  logic [WB_DAT_W-1:0] wb_dat_w,
    output logic                wb_ack,
    output logic [WB_DAT_W-1:0] wb_dat_r,
    output logic                push_row,
    output weight_row_t         row_data,
    output logic                load_bias,
    output param_t              bias_data,
    output logic                load_mode,
    output layer_mode_e         mode_data,
    input  param_t              cur_bias,
    input  layer_mode_e         cur_mode
);

    logic                accept;
    logic [WB_DAT_W-1:0] rd_data;

    // first sampled cycle of a request; the ack cycle itself is masked
    assign accept = wb_cyc & wb_stb & ~wb_ack;

    // write strobes land on the same edge that raises ack
    assign push_row  = accept & wb_we & (wb_adr == REG_WEIGHT);
    assign load_bias = accept & wb_we & (wb_adr == REG_BIAS);
    assign load_mode = accept & wb_we & (wb_adr == REG_MODE);

    assign row_data  = wb_dat_w[$bits(weight_row_t)-1:0];
    assign bias_data = wb_dat_w[BW_PARAM-1:0];
    assign mode_data = layer_mode_e'(wb_dat_w[0]);

    always_comb begin
        case (wb_adr)
            REG_BIAS: rd_data = {{(WB_DAT_W-BW_PARAM){cur_bias[BW_PARAM-1]}}, cur_bias};
            REG_MODE: rd_data = {{(WB_DAT_W-1){1'b0}}, cur_mode};
            // weight rows are write only
            default:  rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= accept;
        end
    end

    // read data is valid only while ack is high
    always_ff @(posedge clk) begin
        if (accept && !wb_we) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule

// ==== hdl/conv_pe_top.sv ====
`timescale 1ns/100ps

// 4-channel 3x3 convolution PE with a wishbone parameter port
module conv_pe_top
    import conv_pkg::*;
#(
    // must be at least the width of one weight row
    parameter int WB_DAT_W = 36
) (
    input  logic                clk,
    input  logic                rst_n,

    // wishbone classic slave
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [1:0]          wb_adr,
    input  logic [WB_DAT_W-1:0] wb_dat_w,
    output logic                wb_ack,
    output logic [WB_DAT_W-1:0] wb_dat_r,

    // activation windows in, pixels out
    input  logic                win_valid,
    input  window_t             win_data,
    output logic                pix_valid,
    output pix_t                pix_data
);

    logic        push_row;
    weight_row_t row_data;
    logic        load_bias;
    param_t      bias_data;
    logic        load_mode;
    layer_mode_e mode_data;

    weight_set_t weights;
    param_t      bias;
    layer_mode_e mode;

    param_port #(
        .WB_DAT_W (WB_DAT_W)
    ) u_param_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_ack    (wb_ack),
        .wb_dat_r  (wb_dat_r),
        .push_row  (push_row),
        .row_data  (row_data),
        .load_bias (load_bias),
        .bias_data (bias_data),
        .load_mode (load_mode),
        .mode_data (mode_data),
        .cur_bias  (bias),
        .cur_mode  (mode)
    );

    weight_bank u_weight_bank (
        .clk       (clk),
        .rst_n     (rst_n),
        .push_row  (push_row),
        .row_data  (row_data),
        .load_bias (load_bias),
        .bias_data (bias_data),
        .load_mode (load_mode),
        .mode_data (mode_data),
        .weights   (weights),
        .bias      (bias),
        .mode      (mode)
    );

    mac_pipe u_mac_pipe (
        .clk       (clk),
        .rst_n     (rst_n),
        .win_valid (win_valid),
        .win_data  (win_data),
        .weights   (weights),
        .bias      (bias),
        .mode      (mode),
        .pix_valid (pix_valid),
        .pix_data  (pix_data)
    );

endmodule

// ==== verif/conv_pe_asserts.sv ====
`timescale 1ns/100ps

// handshake and latency properties, bound into mac_pipe and param_port
module conv_pe_asserts #(
    // which side of the design this instance watches
    parameter bit CHECK_PIX = 1'b1,
    parameter bit CHECK_WB  = 1'b1
) (
    input logic clk,
    input logic rst_n,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic win_valid,
    input logic pix_valid
);

    if (CHECK_PIX) begin : g_pix
        // window sampled at one edge, pixel valid four edges on
        pix_latency: assert property (
            @(posedge clk) disable iff (!rst_n)
            pix_valid == $past(win_valid, 4)
        ) else $error("pix_valid does not follow win_valid by 4 cycles");
    end

    if (CHECK_WB) begin : g_wb
        // single-cycle ack
        ack_single: assert property (
            @(posedge clk) disable iff (!rst_n)
            wb_ack |-> !$past(wb_ack)
        ) else $error("wb_ack high in two consecutive cycles");

        // ack only answers a request seen the cycle before
        ack_after_req: assert property (
            @(posedge clk) disable iff (!rst_n)
            wb_ack |-> $past(wb_cyc && wb_stb)
        ) else $error("wb_ack without a preceding cyc and stb");
    end

endmodule

// ==== verif/conv_pe_tb.sv ====
`timescale 1ns/100ps

module conv_pe_tb
    import conv_pkg::*;
();

    localparam int WB_DAT_W = 36;
    // about 400 cycles of tests, run limit at five times that
    localparam int EST_CYCLES = 400;
    localparam int MAX_CYCLES = 5 * EST_CYCLES;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [1:0]          wb_adr;
    logic [WB_DAT_W-1:0] wb_dat_w;
    logic                wb_ack;
    logic [WB_DAT_W-1:0] wb_dat_r;
    logic                win_valid;
    window_t             win_data;
    logic                pix_valid;
    pix_t                pix_data;

    integer      seed = 89;
    int          cycle_cnt = 0;
    int          last_lat;
    string       cur_test;
    pix_t        exp_q[$];

    // shadow copy of the parameter store
    weight_set_t shadow_w;
    param_t      shadow_bias;
    layer_mode_e shadow_mode;

    conv_pe_top #(
        .WB_DAT_W (WB_DAT_W)
    ) u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_ack    (wb_ack),
        .wb_dat_r  (wb_dat_r),
        .win_valid (win_valid),
        .win_data  (win_data),
        .pix_valid (pix_valid),
        .pix_data  (pix_data)
    );

    bind mac_pipe conv_pe_asserts #(
        .CHECK_PIX (1'b1),
        .CHECK_WB  (1'b0)
    ) u_pipe_asserts (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_cyc    (1'b0),
        .wb_stb    (1'b0),
        .wb_ack    (1'b0),
        .win_valid (win_valid),
        .pix_valid (pix_valid)
    );

    bind param_port conv_pe_asserts #(
        .CHECK_PIX (1'b0),
        .CHECK_WB  (1'b1)
    ) u_wb_asserts (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_ack    (wb_ack),
        .win_valid (1'b0),
        .pix_valid (1'b0)
    );

    always #20 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_pix(input string name, input pix_t exp, input pix_t act);
        if (exp !== act) begin
            abort_run($sformatf("Mismatch in %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_bias(input string name, input param_t exp, input param_t act);
        if (exp !== act) begin
            abort_run($sformatf("Mismatch in %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_mode(input string name, input layer_mode_e exp,
                              input layer_mode_e act);
        if (exp !== act) begin
            abort_run($sformatf("Mismatch in %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_rdata(input string name, input logic [WB_DAT_W-1:0] exp,
                               input logic [WB_DAT_W-1:0] act);
        if (exp !== act) begin
            abort_run($sformatf("Mismatch in %s: expected %0h, actual %0h", name, exp, act));
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (exp != act) begin
            abort_run($sformatf("Mismatch in %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    // sum of products, bias aligned, rounded, shifted and clamped
    function automatic pix_t ref_pixel(input window_t win, input weight_set_t ws,
                                       input param_t b, input layer_mode_e m);
        int acc;
        int val;
        acc = 0;
        for (int c = 0; c < CH_NUM; c++) begin
            for (int t = 0; t < TAPS; t++) begin
                acc += int'($signed(win[c][t])) * int'($signed(ws[c][t]));
            end
        end
        if (m == CONV1) begin
            val = (acc + int'(b) * 128 + 64) >>> 7;
        end else begin
            val = (acc + int'(b) * 8 + 16) >>> 5;
        end
        if (val < 0) begin
            return '0;
        end else if (val > ACT_MAX) begin
            return pix_t'(ACT_MAX);
        end
        return pix_t'(val);
    endfunction

    function automatic window_t rand_window();
        window_t w;
        for (int c = 0; c < CH_NUM; c++) begin
            for (int t = 0; t < TAPS; t++) begin
                w[c][t] = act_t'($random(seed));
            end
        end
        return w;
    endfunction

    function automatic window_t fill_window(input act_t v);
        window_t w;
        for (int c = 0; c < CH_NUM; c++) begin
            for (int t = 0; t < TAPS; t++) begin
                w[c][t] = v;
            end
        end
        return w;
    endfunction

    function automatic weight_row_t rand_row();
        weight_row_t r;
        for (int t = 0; t < TAPS; t++) begin
            r[t] = param_t'($random(seed));
        end
        return r;
    endfunction

    function automatic weight_row_t fill_row(input param_t v);
        weight_row_t r;
        for (int t = 0; t < TAPS; t++) begin
            r[t] = v;
        end
        return r;
    endfunction

    // ack sampled just after each edge, latency counted in cycles
    task automatic wait_ack();
        bit seen;
        seen = 1'b0;
        last_lat = 0;
        while (!seen) begin
            @(posedge clk);
            #1;
            last_lat++;
            if (wb_ack) begin
                seen = 1'b1;
            end else if (last_lat >= 4) begin
                abort_run("no wb_ack within 4 cycles of a request");
            end
        end
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [WB_DAT_W-1:0] dat);
        @(posedge clk);
        #2;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = dat;
        wait_ack();
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [WB_DAT_W-1:0] dat);
        @(posedge clk);
        #2;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_ack();
        dat = wb_dat_r;
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic set_bias(input param_t b);
        logic [WB_DAT_W-1:0] dat;
        dat = '0;
        dat[BW_PARAM-1:0] = b;
        wb_write(REG_BIAS, dat);
        shadow_bias = b;
    endtask

    task automatic set_mode(input layer_mode_e m);
        logic [WB_DAT_W-1:0] dat;
        dat = '0;
        dat[0] = m;
        wb_write(REG_MODE, dat);
        shadow_mode = m;
    endtask

    // newest row lands in group 3, group 0 drops out
    task automatic load_weight_row(input weight_row_t r);
        logic [WB_DAT_W-1:0] dat;
        dat = '0;
        dat[$bits(weight_row_t)-1:0] = r;
        wb_write(REG_WEIGHT, dat);
        for (int g = 0; g < CH_NUM - 1; g++) begin
            shadow_w[g] = shadow_w[g+1];
        end
        shadow_w[CH_NUM-1] = r;
    endtask

    // valid stays high until idle_cycles drops it
    task automatic send_window(input window_t w);
        @(posedge clk);
        #2;
        win_valid = 1'b1;
        win_data  = w;
        exp_q.push_back(ref_pixel(w, shadow_w, shadow_bias, shadow_mode));
    endtask

    task automatic idle_cycles(input int n);
        @(posedge clk);
        #2;
        win_valid = 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
    endtask

    // pixels checked mid-cycle, in arrival order
    always @(negedge clk) begin
        if (pix_valid) begin
            if (exp_q.size() == 0) begin
                abort_run("pixel output arrived with no window outstanding");
            end else begin
                check_pix(cur_test, exp_q.pop_front(), pix_data);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            abort_run($sformatf("timeout, run did not finish in %0d cycles", cycle_cnt));
        end
    end

    initial begin
        logic [WB_DAT_W-1:0] rd;
        rst_n       = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        win_valid   = 1'b0;
        win_data    = '0;
        shadow_w    = '0;
        shadow_bias = '0;
        shadow_mode = CONV1;
        cur_test    = "reset";
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        cur_test = "param_access";
        set_bias(param_t'(-3));
        check_latency(cur_test, 1, last_lat);
        wb_read(REG_BIAS, rd);
        check_latency(cur_test, 1, last_lat);
        check_bias(cur_test, param_t'(-3), param_t'(rd[BW_PARAM-1:0]));
        // a negative bias reads back sign-extended over the whole bus
        check_rdata(cur_test, WB_DAT_W'(-3), rd);
        set_mode(CONV2);
        check_latency(cur_test, 1, last_lat);
        wb_read(REG_MODE, rd);
        check_latency(cur_test, 1, last_lat);
        check_mode(cur_test, CONV2, layer_mode_e'(rd[0]));
        check_rdata(cur_test, WB_DAT_W'(1), rd);
        set_bias(param_t'(5));
        check_latency(cur_test, 1, last_lat);
        wb_read(REG_BIAS, rd);
        check_latency(cur_test, 1, last_lat);
        check_bias(cur_test, param_t'(5), param_t'(rd[BW_PARAM-1:0]));

        cur_test = "conv1_random";
        set_mode(CONV1);
        repeat (CH_NUM) load_weight_row(rand_row());
        // weight rows are write only and read as zero
        wb_read(REG_WEIGHT, rd);
        check_rdata(cur_test, '0, rd);
        set_bias(param_t'($random(seed)));
        for (int i = 0; i < 40; i++) begin
            send_window(rand_window());
            idle_cycles(1);
        end
        drain();

        cur_test = "conv2_random";
        set_mode(CONV2);
        set_bias(param_t'($random(seed)));
        for (int i = 0; i < 40; i++) begin
            send_window(rand_window());
            idle_cycles(1);
        end
        drain();

        cur_test = "back_to_back";
        for (int i = 0; i < 32; i++) begin
            send_window(rand_window());
        end
        idle_cycles(1);
        drain();

        // -128 * -8 in every tap, full scale positive
        cur_test = "clamp_high";
        set_mode(CONV1);
        set_bias(param_t'(7));
        repeat (CH_NUM) load_weight_row(fill_row(param_t'(-8)));
        repeat (3) send_window(fill_window(act_t'(-128)));
        idle_cycles(1);
        drain();

        cur_test = "clamp_low";
        set_mode(CONV2);
        set_bias(param_t'(-8));
        repeat (3) send_window(fill_window(act_t'(127)));
        idle_cycles(1);
        drain();

        cur_test = "shift_bank";
        set_mode(CONV1);
        repeat (2) load_weight_row(rand_row());
        for (int i = 0; i < 4; i++) begin
            send_window(rand_window());
            idle_cycles(1);
        end
        drain();
        repeat (4) load_weight_row(rand_row());
        for (int i = 0; i < 8; i++) begin
            send_window(rand_window());
            idle_cycles(1);
        end
        drain();

        repeat (4) @(posedge clk);
        if (exp_q.size() == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abort_run($sformatf("%0d windows never produced a pixel", exp_q.size()));
        end
    end

endmodule

// ==== filelist.f ====
common/conv_pkg.sv
weight_bank/weight_bank.sv
mac_pipe/requant_relu.sv
mac_pipe/mac_pipe.sv
hdl/param_port.sv
hdl/conv_pe_top.sv
verif/conv_pe_asserts.sv
verif/conv_pe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module conv_pe_tb \
    -f filelist.f \
    -Mdir obj_dir -o conv_pe_sim

./obj_dir/conv_pe_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
